// File: vlog.f
alu_pkg.sv
alu_shifter.sv
alu_multiplier.sv
alu_divider.sv
alu_control.sv
alu_top.sv
tb_clock.sv
tb_alu.sv

// File: run_sim.sh
#!/bin/sh
# build the ALU testbench with Verilator, run it and scan the log
rm -rf obj_dir sim.log build.log
verilator --binary --timing --top-module tb_alu -f vlog.f -o tb_alu_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_alu_sim > sim.log 2>&1
grep -q "Done: errors found" sim.log && { echo "FAIL, see sim.log"; exit 1; }
grep -q "Done: no errors" sim.log && { echo "PASS"; exit 0; } \
    || { echo "FAIL, run ended without a result, see sim.log"; exit 1; }

// File: tb_alu.sv
module tb_alu;

    localparam int clk_period = 4;
    localparam int reset_cycles = 16;
    localparam int n_logic_ops = 7;
    localparam int n_rand = 20;
    localparam int n_edge = 3;
    localparam int n_shift = 3 * 32;
    localparam int n_mul_rand = 6;
    localparam int n_mul_edge = 3;
    localparam int n_div_rand = 6;
    localparam int n_div_edge = 4;
    localparam int n_mixed = 4;
    localparam int total_ops = n_logic_ops * (n_rand + n_edge) + n_shift
                             + 2 * 4 * (n_mul_rand + n_mul_edge)
                             + 2 * 2 * (n_div_rand + n_div_edge) + n_mixed;
    // 40 cycles per operation on top of the reset time
    localparam int watchdog_time = (total_ops * 40 + reset_cycles) * clk_period;

    localparam logic [alu_pkg::word_width-1:0] most_neg =
        {1'b1, {(alu_pkg::word_width-1){1'b0}}};
    localparam logic [alu_pkg::aluop_width-1:0] logic_ops [n_logic_ops] = '{
        alu_pkg::op_add, alu_pkg::op_sub, alu_pkg::op_and, alu_pkg::op_or,
        alu_pkg::op_xor, alu_pkg::op_slt, alu_pkg::op_sltu
    };
    localparam logic [alu_pkg::aluop_width-1:0] shift_ops [3] = '{
        alu_pkg::op_sll, alu_pkg::op_srl, alu_pkg::op_sra
    };

    logic                            I_clk;
    logic                            I_reset;
    logic                            en;
    logic [alu_pkg::word_width-1:0]  src1;
    logic [alu_pkg::word_width-1:0]  src2;
    logic [alu_pkg::aluop_width-1:0] aluop;
    logic [1:0]                      aluop_signed;
    logic [alu_pkg::word_width-1:0]  result;
    logic                            busy;
    logic [alu_pkg::word_width-1:0]  lsu_addr;
    logic                            lt;
    logic                            ltu;
    logic                            eq;

    integer                          seed;
    int                              errors = 0;
    logic                            pending = 1'b0;
    logic [alu_pkg::aluop_width-1:0] cur_op;
    logic [alu_pkg::word_width-1:0]  exp_result;
    logic [alu_pkg::word_width-1:0]  exp_addr;
    logic                            exp_lt;
    logic                            exp_ltu;
    logic                            exp_eq;

    tb_clock clock_i (
        .I_clk (I_clk)
    );

    alu_top alu_top_i (
        .I_clk        (I_clk),
        .I_reset      (I_reset),
        .en           (en),
        .src1         (src1),
        .src2         (src2),
        .aluop        (aluop),
        .aluop_signed (aluop_signed),
        .result       (result),
        .busy         (busy),
        .lsu_addr     (lsu_addr),
        .lt           (lt),
        .ltu          (ltu),
        .eq           (eq)
    );

    // expected result and flags for one operation
    function automatic logic [alu_pkg::word_width-1:0] alu_model(
        input  logic [alu_pkg::aluop_width-1:0] op,
        input  logic [1:0]                      sgn,
        input  logic [alu_pkg::word_width-1:0]  a,
        input  logic [alu_pkg::word_width-1:0]  b,
        output logic                            lt_o,
        output logic                            ltu_o,
        output logic                            eq_o,
        output logic [alu_pkg::word_width-1:0]  addr_o
    );
        logic [2*alu_pkg::word_width-1:0] a_ext;
        logic [2*alu_pkg::word_width-1:0] b_ext;
        logic [2*alu_pkg::word_width-1:0] prod;
        logic [alu_pkg::word_width-1:0]   quo;
        logic [alu_pkg::word_width-1:0]   rmd;
        logic [alu_pkg::word_width-1:0]   res;
        logic                             div_signed;
        lt_o = $signed(a) < $signed(b);
        ltu_o = a < b;
        eq_o = a == b;
        addr_o = a + b;
        a_ext = {{alu_pkg::word_width{sgn[0] & a[alu_pkg::word_width-1]}}, a};
        b_ext = {{alu_pkg::word_width{sgn[1] & b[alu_pkg::word_width-1]}}, b};
        prod = a_ext * b_ext;
        div_signed = sgn[0] | sgn[1];
        // RISC-V rules for a zero divisor and for signed overflow
        if (b == '0) begin
            quo = '1;
            rmd = a;
        end else if (div_signed && a == most_neg && b == '1) begin
            quo = a;
            rmd = '0;
        end else if (div_signed) begin
            quo = $signed(a) / $signed(b);
            rmd = $signed(a) % $signed(b);
        end else begin
            quo = a / b;
            rmd = a % b;
        end
        case (op)
            alu_pkg::op_sub: res = a - b;
            alu_pkg::op_and: res = a & b;
            alu_pkg::op_or: res = a | b;
            alu_pkg::op_xor: res = a ^ b;
            alu_pkg::op_slt: res = {{(alu_pkg::word_width-1){1'b0}}, lt_o};
            alu_pkg::op_sltu: res = {{(alu_pkg::word_width-1){1'b0}}, ltu_o};
            alu_pkg::op_sll: res = a << b[alu_pkg::shamt_width-1:0];
            alu_pkg::op_srl: res = a >> b[alu_pkg::shamt_width-1:0];
            alu_pkg::op_sra: res = $signed(a) >>> b[alu_pkg::shamt_width-1:0];
            alu_pkg::op_mul: res = prod[alu_pkg::word_width-1:0];
            alu_pkg::op_mulh: res = prod[2*alu_pkg::word_width-1:alu_pkg::word_width];
            alu_pkg::op_div: res = quo;
            alu_pkg::op_rem: res = rmd;
            default: res = a + b;
        endcase
        return res;
    endfunction

    task automatic check(
        input logic [alu_pkg::word_width-1:0] got,
        input logic [alu_pkg::word_width-1:0] expected,
        input string                          what
    );
        if (got !== expected) begin
            errors++;
            $display("CHECK FAILED at time %0t: %s, op %0d src1 %h src2 %h got %h expected %h",
                     $time, what, aluop, src1, src2, got, expected);
            $display("Done: errors found");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // drive one operation on a falling edge and wait until it has been checked
    task automatic issue(
        input logic [alu_pkg::aluop_width-1:0] op,
        input logic [1:0]                      sgn,
        input logic [alu_pkg::word_width-1:0]  a,
        input logic [alu_pkg::word_width-1:0]  b
    );
        en = 1'b1;
        aluop = op;
        aluop_signed = sgn;
        src1 = a;
        src2 = b;
        cur_op = op;
        exp_result = alu_model(op, sgn, a, b, exp_lt, exp_ltu, exp_eq, exp_addr);
        pending = 1'b1;
        wait (!pending);
    endtask

    // one idle cycle lets a finished unit leave its done state
    task automatic drop_en();
        en = 1'b0;
        @(posedge I_clk);
        @(negedge I_clk);
    endtask

    initial begin : compare_proc
        int   busy_cycles;
        logic is_mul;
        logic is_div;
        forever begin
            wait (pending);
            is_mul = (cur_op == alu_pkg::op_mul) || (cur_op == alu_pkg::op_mulh);
            is_div = (cur_op == alu_pkg::op_div) || (cur_op == alu_pkg::op_rem);
            busy_cycles = 0;
            @(posedge I_clk);
            @(negedge I_clk);
            if (!is_mul && !is_div) begin
                check(result, exp_result, "single-cycle result after one cycle");
                check(32'(busy), '0, "busy on a single-cycle op");
            end
            while (busy) begin
                busy_cycles++;
                @(posedge I_clk);
                @(negedge I_clk);
            end
            // busy covers the load cycle plus every iteration
            if (is_mul) begin
                check(32'(busy_cycles + 1), 32'(alu_pkg::mul_steps + 1), "multiply busy length");
            end else if (is_div) begin
                check(32'(busy_cycles + 1), 32'(alu_pkg::div_steps + 1), "divide busy length");
            end
            @(posedge I_clk);
            @(negedge I_clk);
            check(result, exp_result, "result");
            check(lsu_addr, exp_addr, "lsu_addr");
            check(32'(lt), 32'(exp_lt), "lt flag");
            check(32'(ltu), 32'(exp_ltu), "ltu flag");
            check(32'(eq), 32'(exp_eq), "eq flag");
            pending = 1'b0;
        end
    end

    initial begin : watchdog
        #(watchdog_time);
        $display("Timeout: the operations did not finish in the expected time");
        $display("Done: errors found");
        $fatal(1, "watchdog expired");
    end

    initial begin : stimulus
        logic [alu_pkg::word_width-1:0] a;
        logic [alu_pkg::word_width-1:0] b;
        seed = 32'hafd4;
        I_reset = 1'b1;
        en = 1'b0;
        aluop = alu_pkg::op_add;
        aluop_signed = 2'b00;
        src1 = '0;
        src2 = '0;
        repeat (reset_cycles) @(posedge I_clk);
        @(negedge I_clk);
        I_reset = 1'b0;
        check(result, '0, "result after reset");
        check(32'(busy), '0, "busy after reset");

        // single-cycle arithmetic, logic and compares
        for (int k = 0; k < n_logic_ops; k++) begin
            for (int i = 0; i < n_rand; i++) begin
                a = $random(seed);
                b = $random(seed);
                issue(logic_ops[k], 2'b00, a, b);
            end
            a = $random(seed);
            issue(logic_ops[k], 2'b00, a, a);
            issue(logic_ops[k], 2'b00, most_neg, '0);
            issue(logic_ops[k], 2'b00, '1, 32'd1);
        end

        // every shift amount, odd amounts with a negative operand
        for (int k = 0; k < 3; k++) begin
            for (int amt = 0; amt < 32; amt++) begin
                a = $random(seed);
                a[alu_pkg::word_width-1] = amt[0];
                b = $random(seed);
                b[alu_pkg::shamt_width-1:0] = amt[alu_pkg::shamt_width-1:0];
                issue(shift_ops[k], 2'b00, a, b);
            end
        end

        for (int s = 0; s < 4; s++) begin
            for (int k = 0; k < 2; k++) begin
                for (int i = 0; i < n_mul_rand; i++) begin
                    a = $random(seed);
                    b = $random(seed);
                    issue(k == 0 ? alu_pkg::op_mul : alu_pkg::op_mulh, 2'(s), a, b);
                    drop_en();
                end
                issue(k == 0 ? alu_pkg::op_mul : alu_pkg::op_mulh, 2'(s), most_neg, most_neg);
                drop_en();
                issue(k == 0 ? alu_pkg::op_mul : alu_pkg::op_mulh, 2'(s), most_neg, '1);
                drop_en();
                issue(k == 0 ? alu_pkg::op_mul : alu_pkg::op_mulh, 2'(s), '1, '1);
                drop_en();
            end
        end

        // unsigned and signed division
        for (int s = 0; s < 2; s++) begin
            for (int k = 0; k < 2; k++) begin
                for (int i = 0; i < n_div_rand; i++) begin
                    a = $random(seed);
                    b = $random(seed);
                    b = b >> (4 * i);
                    issue(k == 0 ? alu_pkg::op_div : alu_pkg::op_rem, s == 0 ? 2'b00 : 2'b11, a, b);
                    drop_en();
                end
                a = $random(seed);
                issue(k == 0 ? alu_pkg::op_div : alu_pkg::op_rem, s == 0 ? 2'b00 : 2'b11, a, '0);
                drop_en();
                issue(k == 0 ? alu_pkg::op_div : alu_pkg::op_rem, s == 0 ? 2'b00 : 2'b11,
                      most_neg, '1);
                drop_en();
                issue(k == 0 ? alu_pkg::op_div : alu_pkg::op_rem, s == 0 ? 2'b00 : 2'b11,
                      most_neg, 32'd7);
                drop_en();
                issue(k == 0 ? alu_pkg::op_div : alu_pkg::op_rem, s == 0 ? 2'b00 : 2'b11,
                      32'd5, most_neg);
                drop_en();
            end
        end

        // a single-cycle op right behind a multi-cycle op
        a = $random(seed);
        b = $random(seed);
        issue(alu_pkg::op_mul, 2'b11, a, b);
        issue(alu_pkg::op_add, 2'b00, b, a);
        drop_en();
        issue(alu_pkg::op_div, 2'b01, a, b);
        issue(alu_pkg::op_sub, 2'b00, a, b);
        drop_en();

        if (errors == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("Done: errors found");
            $fatal(1, "checks failed");
        end
    end

endmodule

// File: tb_clock.sv
module tb_clock (
    output logic I_clk
);

    // free-running clock with a period of 4
    initial begin
        I_clk = 1'b0;
        forever begin
            #2 I_clk = ~I_clk;
        end
    end

endmodule

// File: alu_top.sv
module alu_top (
    input  logic                            I_clk,
    input  logic                            I_reset,
    input  logic                            en,
    input  logic [alu_pkg::word_width-1:0]  src1,
    input  logic [alu_pkg::word_width-1:0]  src2,
    input  logic [alu_pkg::aluop_width-1:0] aluop,
    input  logic [1:0]                      aluop_signed,
    output logic [alu_pkg::word_width-1:0]  result,
    output logic                            busy,
    output logic [alu_pkg::word_width-1:0]  lsu_addr,
    output logic                            lt,
    output logic                            ltu,
    output logic                            eq
);

    logic [alu_pkg::word_width-1:0]   shift_out;
    logic [2*alu_pkg::word_width-1:0] product;
    logic                             mul_busy;
    logic [alu_pkg::word_width-1:0]   div_out;
    logic                             div_busy;
    logic                             start_mul;
    logic                             start_div;
    logic                             is_rem;
    logic                             shift_left;
    logic                             shift_arith;
    logic                             div_signed;

    // division is signed when either operand is marked signed
    assign div_signed = aluop_signed[0] || aluop_signed[1];

    alu_control control_i (
        .I_clk        (I_clk),
        .I_reset      (I_reset),
        .en           (en),
        .aluop        (aluop),
        .aluop_signed (aluop_signed),
        .src1         (src1),
        .src2         (src2),
        .shift_out    (shift_out),
        .product      (product),
        .mul_busy     (mul_busy),
        .div_out      (div_out),
        .div_busy     (div_busy),
        .result       (result),
        .busy         (busy),
        .lsu_addr     (lsu_addr),
        .lt           (lt),
        .ltu          (ltu),
        .eq           (eq),
        .start_mul    (start_mul),
        .start_div    (start_div),
        .is_rem       (is_rem),
        .shift_left   (shift_left),
        .shift_arith  (shift_arith)
    );

    alu_shifter shifter_i (
        .data        (src1),
        .shamt       (src2[alu_pkg::shamt_width-1:0]),
        .shift_left  (shift_left),
        .shift_arith (shift_arith),
        .shift_out   (shift_out)
    );

    alu_multiplier mul_i (
        .I_clk     (I_clk),
        .I_reset   (I_reset),
        .start     (start_mul),
        .op_signed (aluop_signed),
        .src1      (src1),
        .src2      (src2),
        .product   (product),
        .busy      (mul_busy)
    );

    alu_divider div_i (
        .I_clk     (I_clk),
        .I_reset   (I_reset),
        .start     (start_div),
        .is_rem    (is_rem),
        .is_signed (div_signed),
        .dividend  (src1),
        .divisor   (src2),
        .div_out   (div_out),
        .busy      (div_busy)
    );

endmodule

// File: alu_control.sv
module alu_control (
    input  logic                                 I_clk,
    input  logic                                 I_reset,
    input  logic                                 en,
    input  logic [alu_pkg::aluop_width-1:0]      aluop,
    input  logic [1:0]                           aluop_signed,
    input  logic [alu_pkg::word_width-1:0]       src1,
    input  logic [alu_pkg::word_width-1:0]       src2,
    input  logic [alu_pkg::word_width-1:0]       shift_out,
    input  logic [2*alu_pkg::word_width-1:0]     product,
    input  logic                                 mul_busy,
    input  logic [alu_pkg::word_width-1:0]       div_out,
    input  logic                                 div_busy,
    output logic [alu_pkg::word_width-1:0]       result,
    output logic                                 busy,
    output logic [alu_pkg::word_width-1:0]       lsu_addr,
    output logic                                 lt,
    output logic                                 ltu,
    output logic                                 eq,
    output logic                                 start_mul,
    output logic                                 start_div,
    output logic                                 is_rem,
    output logic                                 shift_left,
    output logic                                 shift_arith
);

    logic [alu_pkg::word_width-1:0] sum;
    logic [alu_pkg::word_width:0]   diff;
    logic [alu_pkg::word_width-1:0] and_word;
    logic [alu_pkg::word_width-1:0] or_word;
    logic [alu_pkg::word_width-1:0] xor_word;
    logic                           is_mul_op;
    logic                           is_div_op;

    // operation decode
    assign is_mul_op = (aluop == alu_pkg::op_mul) || (aluop == alu_pkg::op_mulh);
    assign is_div_op = (aluop == alu_pkg::op_div) || (aluop == alu_pkg::op_rem);

    // start levels follow en, the units hold in done until these drop
    assign start_mul = en && is_mul_op;
    assign start_div = en && is_div_op;
    assign is_rem = (aluop == alu_pkg::op_rem);

    assign shift_left = (aluop == alu_pkg::op_sll);
    assign shift_arith = (aluop == alu_pkg::op_sra);

    assign busy = mul_busy || div_busy;

    // adder, subtractor and logic words
    assign sum = src1 + src2;
    assign diff = {1'b0, src1} - {1'b0, src2};
    assign and_word = src1 & src2;
    assign or_word = src1 | src2;
    assign xor_word = src1 ^ src2;

    // borrow out of the 33-bit difference gives the unsigned compare
    assign ltu = diff[alu_pkg::word_width];
    // operands of different sign flip the borrow for the signed compare
    assign lt = diff[alu_pkg::word_width] ^ xor_word[alu_pkg::word_width-1];
    assign eq = (src1 == src2);

    assign lsu_addr = sum;

    always_ff @(posedge I_clk) begin
        if (I_reset) begin
            result <= '0;
        end else if (en) begin
            case (aluop)
                alu_pkg::op_sub: begin
                    result <= diff[alu_pkg::word_width-1:0];
                end
                alu_pkg::op_and: begin
                    result <= and_word;
                end
                alu_pkg::op_or: begin
                    result <= or_word;
                end
                alu_pkg::op_xor: begin
                    result <= xor_word;
                end
                alu_pkg::op_slt: begin
                    result <= {{(alu_pkg::word_width-1){1'b0}}, lt};
                end
                alu_pkg::op_sltu: begin
                    result <= {{(alu_pkg::word_width-1){1'b0}}, ltu};
                end
                alu_pkg::op_sll, alu_pkg::op_srl, alu_pkg::op_sra: begin
                    result <= shift_out;
                end
                alu_pkg::op_mul: begin
                    result <= product[alu_pkg::word_width-1:0];
                end
                alu_pkg::op_mulh: begin
                    // operand signs are already applied inside the multiplier
                    result <= product[2*alu_pkg::word_width-1:alu_pkg::word_width];
                end
                alu_pkg::op_div, alu_pkg::op_rem: begin
                    result <= div_out;
                end
                default: begin
                    result <= sum;
                end
            endcase
        end
    end

endmodule

// File: alu_divider.sv
module alu_divider (
    input  logic                           I_clk,
    input  logic                           I_reset,
    input  logic                           start,
    input  logic                           is_rem,
    input  logic                           is_signed,
    input  logic [alu_pkg::word_width-1:0] dividend,
    input  logic [alu_pkg::word_width-1:0] divisor,
    output logic [alu_pkg::word_width-1:0] div_out,
    output logic                           busy
);

    logic [1:0]                        state;
    logic [alu_pkg::div_cnt_width-1:0] step_cnt;
    logic                              neg_a;
    logic                              neg_b;
    logic [alu_pkg::word_width-1:0]    mag_a;
    logic [alu_pkg::word_width-1:0]    mag_b;
    logic [alu_pkg::word_width-1:0]    quot;
    logic [alu_pkg::word_width-1:0]    rem;
    logic [alu_pkg::word_width-1:0]    dsor;
    logic [alu_pkg::word_width-1:0]    dvd_orig;
    logic                              neg_q;
    logic                              neg_r;
    logic                              div_zero;
    logic                              rem_sel;
    logic [alu_pkg::word_width:0]      shifted;
    logic [alu_pkg::word_width:0]      trial;
    logic [alu_pkg::word_width-1:0]    quot_out;
    logic [alu_pkg::word_width-1:0]    rem_out;

    assign neg_a = is_signed && dividend[alu_pkg::word_width-1];
    assign neg_b = is_signed && divisor[alu_pkg::word_width-1];
    assign mag_a = neg_a ? -dividend : dividend;
    assign mag_b = neg_b ? -divisor : divisor;

    // bring the next dividend bit into the partial remainder and try a subtract
    assign shifted = {rem, quot[alu_pkg::word_width-1]};
    assign trial = shifted - {1'b0, dsor};

    assign busy = ((state == alu_pkg::st_idle) && start) || (state == alu_pkg::st_run);

    // quotient sign is the xor of operand signs, remainder follows the dividend
    assign quot_out = neg_q ? -quot : quot;
    assign rem_out = neg_r ? -rem : rem;

    // most negative over minus one needs no special case here,
    // the magnitude path already yields the dividend and a zero remainder
    always_comb begin
        if (div_zero) begin
            div_out = rem_sel ? dvd_orig : '1;
        end else begin
            div_out = rem_sel ? rem_out : quot_out;
        end
    end

    always_ff @(posedge I_clk) begin
        if (I_reset) begin
            state <= alu_pkg::st_idle;
            step_cnt <= '0;
        end else begin
            case (state)
                alu_pkg::st_idle: begin
                    step_cnt <= '0;
                    if (start) begin
                        state <= alu_pkg::st_run;
                    end
                end
                alu_pkg::st_run: begin
                    step_cnt <= step_cnt + 1'b1;
                    if (32'(step_cnt) == alu_pkg::div_steps - 1) begin
                        state <= alu_pkg::st_done;
                    end
                end
                alu_pkg::st_done: begin
                    if (!start) begin
                        state <= alu_pkg::st_idle;
                    end
                end
                default: begin
                    state <= alu_pkg::st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge I_clk) begin
        if (state == alu_pkg::st_idle) begin
            quot <= mag_a;
            rem <= '0;
            dsor <= mag_b;
            dvd_orig <= dividend;
            neg_q <= neg_a ^ neg_b;
            neg_r <= neg_a;
            div_zero <= (divisor == '0);
            rem_sel <= is_rem;
        end else if (state == alu_pkg::st_run) begin
            if (!trial[alu_pkg::word_width]) begin
                rem <= trial[alu_pkg::word_width-1:0];
                quot <= {quot[alu_pkg::word_width-2:0], 1'b1};
            end else begin
                // restore, the subtract went negative
                rem <= shifted[alu_pkg::word_width-1:0];
                quot <= {quot[alu_pkg::word_width-2:0], 1'b0};
            end
        end
    end

endmodule

// File: alu_multiplier.sv
module alu_multiplier (
    input  logic                             I_clk,
    input  logic                             I_reset,
    input  logic                             start,
    input  logic [1:0]                       op_signed,
    input  logic [alu_pkg::word_width-1:0]   src1,
    input  logic [alu_pkg::word_width-1:0]   src2,
    output logic [2*alu_pkg::word_width-1:0] product,
    output logic                             busy
);

    logic [1:0]                         state;
    logic [alu_pkg::mul_cnt_width-1:0]  step_cnt;
    logic                               neg1;
    logic                               neg2;
    logic [alu_pkg::word_width-1:0]     mag1;
    logic [alu_pkg::word_width-1:0]     mag2;
    logic [alu_pkg::word_width-1:0]     mcand;
    logic [2*alu_pkg::word_width-1:0]   acc;
    logic [alu_pkg::word_width:0]       partial;
    logic                               negate;

    // operand magnitudes, a signed operand is negative when its msb is set
    assign neg1 = op_signed[0] && src1[alu_pkg::word_width-1];
    assign neg2 = op_signed[1] && src2[alu_pkg::word_width-1];
    assign mag1 = neg1 ? -src1 : src1;
    assign mag2 = neg2 ? -src2 : src2;

    // upper half accumulates the multiplicand when the multiplier lsb is set
    assign partial = {1'b0, acc[2*alu_pkg::word_width-1:alu_pkg::word_width]}
                   + (acc[0] ? {1'b0, mcand} : '0);

    assign busy = ((state == alu_pkg::st_idle) && start) || (state == alu_pkg::st_run);

    assign product = negate ? -acc : acc;

    always_ff @(posedge I_clk) begin
        if (I_reset) begin
            state <= alu_pkg::st_idle;
            step_cnt <= '0;
        end else begin
            case (state)
                alu_pkg::st_idle: begin
                    step_cnt <= '0;
                    if (start) begin
                        state <= alu_pkg::st_run;
                    end
                end
                alu_pkg::st_run: begin
                    step_cnt <= step_cnt + 1'b1;
                    if (32'(step_cnt) == alu_pkg::mul_steps - 1) begin
                        state <= alu_pkg::st_done;
                    end
                end
                alu_pkg::st_done: begin
                    // wait for the start level to drop
                    if (!start) begin
                        state <= alu_pkg::st_idle;
                    end
                end
                default: begin
                    state <= alu_pkg::st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge I_clk) begin
        if (state == alu_pkg::st_idle) begin
            mcand <= mag1;
            acc <= {{alu_pkg::word_width{1'b0}}, mag2};
            negate <= neg1 ^ neg2;
        end else if (state == alu_pkg::st_run) begin
            acc <= {partial, acc[alu_pkg::word_width-1:1]};
        end
    end

endmodule

// File: alu_shifter.sv
module alu_shifter (
    input  logic [alu_pkg::word_width-1:0]  data,
    input  logic [alu_pkg::shamt_width-1:0] shamt,
    input  logic                            shift_left,
    input  logic                            shift_arith,
    output logic [alu_pkg::word_width-1:0]  shift_out
);

    logic [alu_pkg::word_width-1:0] data_rev;
    logic [alu_pkg::word_width-1:0] right_out;
    logic [alu_pkg::word_width-1:0] right_rev;
    logic                           fill;

    // a left shift is a right shift of the bit-reversed word
    assign data_rev = {<<{data}};
    assign fill = shift_arith && data[alu_pkg::word_width-1];

    always_comb begin
        logic [alu_pkg::word_width-1:0] v;
        logic [alu_pkg::word_width-1:0] mask;
        v = shift_left ? data_rev : data;
        // log2 stages, each one shifts by a power of two
        for (int s = 0; s < alu_pkg::shamt_width; s++) begin
            mask = ~({alu_pkg::word_width{1'b1}} >> (1 << s));
            if (shamt[s]) begin
                v = (v >> (1 << s)) | (fill ? mask : '0);
            end
        end
        right_out = v;
    end

    assign right_rev = {<<{right_out}};
    assign shift_out = shift_left ? right_rev : right_out;

endmodule

// File: alu_pkg.sv
package alu_pkg;

    // datapath widths
    localparam int word_width = 32;
    localparam int shamt_width = 5;
    localparam int aluop_width = 4;

    // operation codes
    localparam logic [aluop_width-1:0] op_add = 4'd0;
    localparam logic [aluop_width-1:0] op_sub = 4'd1;
    localparam logic [aluop_width-1:0] op_and = 4'd2;
    localparam logic [aluop_width-1:0] op_or = 4'd3;
    localparam logic [aluop_width-1:0] op_xor = 4'd4;

    // set-less-than, result is 0 or 1
    localparam logic [aluop_width-1:0] op_slt = 4'd5;
    localparam logic [aluop_width-1:0] op_sltu = 4'd6;

    // shift amount is taken from the low bits of src2
    localparam logic [aluop_width-1:0] op_sll = 4'd7;
    localparam logic [aluop_width-1:0] op_srl = 4'd8;
    localparam logic [aluop_width-1:0] op_sra = 4'd9;

    // multi-cycle operations
    localparam logic [aluop_width-1:0] op_mul = 4'd10;
    localparam logic [aluop_width-1:0] op_mulh = 4'd11;
    localparam logic [aluop_width-1:0] op_div = 4'd12;
    localparam logic [aluop_width-1:0] op_rem = 4'd13;

    // codes 14 and 15 are unassigned and fall back to add

    // iteration counts of the sequential units
    localparam int mul_steps = 32;
    localparam int div_steps = 32;
    localparam int mul_cnt_width = $clog2(mul_steps);
    localparam int div_cnt_width = $clog2(div_steps);

    // FSM encoding shared by the multiplier and the divider
    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_run = 2'd1;
    localparam logic [1:0] st_done = 2'd2;

endpackage
